/* compile.f */
+incdir+include
design/core_pkg.sv
design/core_fetch.sv
design/core_decode.sv
design/core_exec.sv
design/core_irq_ctrl.sv
design/core_top.sv
dv/core_mem_model.sv
dv/core_tb.sv

/* dv/core_tb.sv */
////////////////////////////////////////////////////////////
// core testbench
// runs the program without and with bus stalls and checks
// every write and acknowledge against the event table
////////////////////////////////////////////////////////////
`default_nettype none
`include "core_config.svh"

module core_tb ();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {ev_write, ev_inta, ev_nmia} ev_kind_t;

  localparam int EV_MAX = 32;
  localparam int ST_MAX = 16;

  logic               clk;
  logic               rst;
  logic               intr;
  logic               nmi;
  logic               stall_en;
  logic               inta;
  logic               nmia;
  logic               cpu_we;
  logic               cpu_block;
  logic [`ADDR_W-1:0] cpu_adr;
  logic [`ADDR_W-1:0] pc;
  logic [`DATA_W-1:0] rd_data;
  logic [`DATA_W-1:0] wr_data;

  // expected bus events
  // acknowledges keep the pc at acceptance in ev_addr
  ev_kind_t           ev_kind  [EV_MAX];
  logic [`ADDR_W-1:0] ev_addr  [EV_MAX];
  logic [`DATA_W-1:0] ev_data  [EV_MAX];
  int                 ev_cycle [EV_MAX];
  int                 n_ev = 0;
  int                 ev_idx = 0;

  // input steps with a delay in cycles after event st_trig
  int                 st_trig  [ST_MAX];
  int                 st_delay [ST_MAX];
  logic               st_nmi   [ST_MAX];
  logic               st_val   [ST_MAX];
  int                 n_st = 0;

  int                 cycle = 0;

  core_top uut (
    .clk         (clk),
    .rst         (rst),
    .intr_i      (intr),
    .inta_o      (inta),
    .nmi_i       (nmi),
    .nmia_o      (nmia),
    .cpu_adr_o   (cpu_adr),
    .cpu_dat_i   (rd_data),
    .cpu_dat_o   (wr_data),
    .cpu_we_o    (cpu_we),
    .cpu_block_i (cpu_block),
    .pc_o        (pc)
  );

  core_mem_model mem (
    .clk        (clk),
    .rst        (rst),
    .stall_en_i (stall_en),
    .adr_i      (cpu_adr),
    .dat_i      (wr_data),
    .we_i       (cpu_we),
    .dat_o      (rd_data),
    .block_o    (cpu_block)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic add_event(ev_kind_t k, logic [`ADDR_W-1:0] a, logic [`DATA_W-1:0] d);
    ev_kind[n_ev] = k;
    ev_addr[n_ev] = a;
    ev_data[n_ev] = d;
    n_ev++;
  endtask

  task automatic add_step(int trig, int delay, logic on_nmi, logic val);
    st_trig[n_st]  = trig;
    st_delay[n_st] = delay;
    st_nmi[n_st]   = on_nmi;
    st_val[n_st]   = val;
    n_st++;
  endtask

  task automatic load_tables();
    add_event(ev_write, 20'h000c0, 16'h0025 + 16'h0013);
    // first sub leaves 25 so jz falls through
    add_event(ev_write, 20'h000c1, 16'h0038 - 16'h0013);
    add_event(ev_write, 20'h000c2, 16'h0025 - 16'h0025);
    add_event(ev_write, 20'h000c3, 16'h0038);
    add_event(ev_write, 20'h000c4, 16'h00c4);
    add_event(ev_write, 20'h000c5, 16'h00c5);
    // halted after the hlt at 19
    add_event(ev_inta,  20'h0001a, 16'h0000);
    add_event(ev_write, 20'h000d0, 16'h00d0);
    add_event(ev_write, 20'h000c6, 16'h00c6);
    add_event(ev_write, 20'h000c7, 16'h00c7);
    add_event(ev_nmia,  20'h0001f, 16'h0000);
    add_event(ev_write, 20'h000e0, 16'h0055);
    add_event(ev_write, 20'h000c8, 16'h0055);
    add_event(ev_write, 20'h000c9, 16'h00c9);
    // intr high across two masked instructions
    add_step(4, 0, 1'b0, 1'b1);
    add_step(5, 0, 1'b0, 1'b0);
    // wake from hlt well after the sti
    add_step(5, 20, 1'b0, 1'b1);
    add_step(6, 0, 1'b0, 1'b0);
    // nmi edge held high past the handler
    add_step(9, 0, 1'b1, 1'b1);
    add_step(13, 0, 1'b1, 1'b0);
  endtask

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_addr(string name, logic [`ADDR_W-1:0] got, logic [`ADDR_W-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR time %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(string name, logic [`DATA_W-1:0] got, logic [`DATA_W-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR time %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pulse(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("ERROR time %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic take_event(ev_kind_t seen);
    if (ev_idx >= n_ev)
    begin
      $display("unexpected bus event at time %0t after the last table entry", $time);
      abort_run();
    end
    else
    begin
      case (seen)
        ev_write:
        begin
          check_pulse("cpu_we_o", 1'b1, ev_kind[ev_idx] == ev_write);
          check_addr("cpu_adr_o", cpu_adr, ev_addr[ev_idx]);
          check_word("cpu_dat_o", wr_data, ev_data[ev_idx]);
        end
        ev_inta:
        begin
          check_pulse("inta_o", 1'b1, ev_kind[ev_idx] == ev_inta);
          check_addr("pc_o", pc, ev_addr[ev_idx]);
          check_addr("cpu_adr_o", cpu_adr, ev_addr[ev_idx]);
        end
        default:
        begin
          check_pulse("nmia_o", 1'b1, ev_kind[ev_idx] == ev_nmia);
          check_addr("pc_o", pc, ev_addr[ev_idx]);
          check_addr("cpu_adr_o", cpu_adr, ev_addr[ev_idx]);
        end
      endcase
      ev_cycle[ev_idx] = cycle;
      ev_idx++;
    end
  endtask

  // outputs read at the rising edge before the flops move
  always @(posedge clk)
  begin
    cycle++;
    if (rst)
    begin
      if (cpu_we && !cpu_block)
        take_event(ev_write);
      if (inta)
        take_event(ev_inta);
      if (nmia)
        take_event(ev_nmia);
    end
  end

  task automatic start_run(logic stalls);
    @(negedge clk);
    rst      = 1'b0;
    intr     = 1'b0;
    nmi      = 1'b0;
    stall_en = stalls;
    repeat (5) @(negedge clk);
    ev_idx = 0;
    rst    = 1'b1;
  endtask

  task automatic apply_step(int s);
    wait (ev_idx > st_trig[s]);
    @(negedge clk);
    while (cycle < ev_cycle[st_trig[s]] + st_delay[s])
      @(negedge clk);
    if (st_nmi[s])
      nmi = st_val[s];
    else
      intr = st_val[s];
  endtask

  // generous bound per table entry and run
  initial
  begin
    wait (n_ev != 0);
    repeat (2 * n_ev * 200) @(posedge clk);
    $display("timeout, the core did not reach the end of the event table");
    abort_run();
  end

  initial
  begin
    rst      = 1'b0;
    intr     = 1'b0;
    nmi      = 1'b0;
    stall_en = 1'b0;
    load_tables();
    for (int run = 0; run < 2; run++)
    begin
      start_run(run != 0);
      for (int s = 0; s < n_st; s++)
        apply_step(s);
      wait (ev_idx == n_ev);
      // quiet period catches stray writes or pulses
      repeat (20) @(posedge clk);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/core_mem_model.sv */
////////////////////////////////////////////////////////////
// word memory model
// holds the test program and data area, stretches bus
// cycles from an lfsr when stalls are enabled
////////////////////////////////////////////////////////////
`default_nettype none
`include "core_config.svh"

module core_mem_model
  import core_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               stall_en_i,
  input  logic [`ADDR_W-1:0] adr_i,
  input  logic [`DATA_W-1:0] dat_i,
  input  logic               we_i,
  output logic [`DATA_W-1:0] dat_o,
  output logic               block_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          DEPTH = 256;
  localparam logic [23:0] SEED  = 24'd84798;

  logic [`DATA_W-1:0] mem [DEPTH];
  logic [23:0]        lfsr = SEED;
  logic               stall = 1'b0;

  // x^24 + x^23 + x^22 + x^17 + 1
  function automatic logic [23:0] lfsr_step(logic [23:0] s);
    return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
  endfunction

  function automatic logic [`DATA_W-1:0] fill_word(logic [`ADDR_W-1:0] a);
    return a[15:0] ^ {a[3:0], a[19:8]} ^ 16'hb6e5;
  endfunction

  function automatic logic [`DATA_W-1:0] enc(opcode_t op, logic [1:0] d, logic [1:0] s,
                                              logic [7:0] imm);
    return {op, d, s, imm};
  endfunction

  task automatic load_image();
    for (int i = 0; i < DEPTH; i++)
      mem[i] <= fill_word(`ADDR_W'(i));
    // alu results and jz markers
    mem[8'h00] <= enc(op_ldi,  2'd3, 2'd0, 8'hc0);
    mem[8'h01] <= enc(op_ldi,  2'd0, 2'd0, 8'h25);
    mem[8'h02] <= enc(op_ldi,  2'd1, 2'd0, 8'h13);
    mem[8'h03] <= enc(op_add,  2'd0, 2'd1, 8'h00);
    mem[8'h04] <= enc(op_st,   2'd0, 2'd3, 8'h00);
    mem[8'h05] <= enc(op_sub,  2'd0, 2'd1, 8'h00);
    mem[8'h06] <= enc(op_jz,   2'd0, 2'd0, 8'h09);
    mem[8'h07] <= enc(op_ldi,  2'd3, 2'd0, 8'hc1);
    mem[8'h08] <= enc(op_st,   2'd0, 2'd3, 8'h00);
    mem[8'h09] <= enc(op_ldi,  2'd3, 2'd0, 8'hc2);
    mem[8'h0a] <= enc(op_ldi,  2'd2, 2'd0, 8'h25);
    mem[8'h0b] <= enc(op_sub,  2'd2, 2'd0, 8'h00);
    mem[8'h0c] <= enc(op_jz,   2'd0, 2'd0, 8'h0e);
    // skipped when the branch works
    mem[8'h0d] <= enc(op_st,   2'd3, 2'd3, 8'h00);
    mem[8'h0e] <= enc(op_st,   2'd2, 2'd3, 8'h00);
    mem[8'h0f] <= enc(op_ldi,  2'd3, 2'd0, 8'hc0);
    mem[8'h10] <= enc(op_ld,   2'd1, 2'd3, 8'h00);
    mem[8'h11] <= enc(op_ldi,  2'd3, 2'd0, 8'hc3);
    mem[8'h12] <= enc(op_st,   2'd1, 2'd3, 8'h00);
    // masked stores, then sti and hlt
    mem[8'h13] <= enc(op_stci, 2'd0, 2'd0, 8'h00);
    mem[8'h14] <= enc(op_ldi,  2'd3, 2'd0, 8'hc4);
    mem[8'h15] <= enc(op_st,   2'd3, 2'd3, 8'h00);
    mem[8'h16] <= enc(op_ldi,  2'd3, 2'd0, 8'hc5);
    mem[8'h17] <= enc(op_st,   2'd3, 2'd3, 8'h00);
    mem[8'h18] <= enc(op_stci, 2'd0, 2'd0, 8'h01);
    mem[8'h19] <= enc(op_hlt,  2'd0, 2'd0, 8'h00);
    mem[8'h1a] <= enc(op_ldi,  2'd3, 2'd0, 8'hc6);
    mem[8'h1b] <= enc(op_st,   2'd3, 2'd3, 8'h00);
    // nmi lands on the ldi at 1f
    mem[8'h1c] <= enc(op_stci, 2'd0, 2'd0, 8'h00);
    mem[8'h1d] <= enc(op_ldi,  2'd3, 2'd0, 8'hc7);
    mem[8'h1e] <= enc(op_st,   2'd3, 2'd3, 8'h00);
    mem[8'h1f] <= enc(op_ldi,  2'd0, 2'd0, 8'h55);
    mem[8'h20] <= enc(op_ldi,  2'd3, 2'd0, 8'hc8);
    mem[8'h21] <= enc(op_st,   2'd0, 2'd3, 8'h00);
    mem[8'h22] <= enc(op_ldi,  2'd3, 2'd0, 8'hc9);
    mem[8'h23] <= enc(op_st,   2'd3, 2'd3, 8'h00);
    mem[8'h24] <= enc(op_hlt,  2'd0, 2'd0, 8'h00);
    // maskable handler
    mem[8'h40] <= enc(op_ldi,  2'd3, 2'd0, 8'hd0);
    mem[8'h41] <= enc(op_st,   2'd3, 2'd3, 8'h00);
    mem[8'h42] <= enc(op_iret, 2'd0, 2'd0, 8'h00);
    // nmi handler
    mem[8'h80] <= enc(op_nop,  2'd0, 2'd0, 8'h00);
    mem[8'h81] <= enc(op_ldi,  2'd3, 2'd0, 8'he0);
    mem[8'h82] <= enc(op_st,   2'd0, 2'd3, 8'h00);
    mem[8'h83] <= enc(op_iret, 2'd0, 2'd0, 8'h00);
  endtask

  // image and lfsr restart with every reset
  always @(negedge clk)
  begin
    if (!rst)
    begin
      load_image();
      lfsr  = SEED;
      stall = 1'b0;
    end
    else if (stall_en_i)
    begin
      lfsr  = lfsr_step(lfsr);
      stall = lfsr[0];
    end
    else
      stall = 1'b0;
  end

  always @(posedge clk)
  begin
    if (rst && we_i && !stall && adr_i[`ADDR_W-1:8] == '0)
      mem[adr_i[7:0]] <= dat_i;
  end

  assign dat_o   = (adr_i[`ADDR_W-1:8] == '0) ? mem[adr_i[7:0]] : fill_word(adr_i);
  assign block_o = stall;

endmodule

`default_nettype wire

/* design/core_top.sv */
////////////////////////////////////////////////////////////
// core top level
// ties fetch, decode, execute and interrupt control
// together and muxes the bus address
////////////////////////////////////////////////////////////
`default_nettype none
`include "core_config.svh"

module core_top
  import core_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               intr_i,
  output logic               inta_o,
  input  logic               nmi_i,
  output logic               nmia_o,
  output logic [`ADDR_W-1:0] cpu_adr_o,
  input  logic [`DATA_W-1:0] cpu_dat_i,
  output logic [`DATA_W-1:0] cpu_dat_o,
  output logic               cpu_we_o,
  input  logic               cpu_block_i,
  output logic [`ADDR_W-1:0] pc_o
);

  logic [`DATA_W-1:0]        instr;
  seq_state_t                state;
  logic [`ADDR_W-1:0]        pc;
  logic [`ADDR_W-1:0]        redirect_pc;
  logic [`ADDR_W-1:0]        mem_adr;
  alu_op_t                   alu_op;
  logic [$clog2(`NREGS)-1:0] dst;
  logic [$clog2(`NREGS)-1:0] src;
  logic                      reg_we;
  logic                      mem_rd;
  logic                      mem_wr;
  logic                      set_if;
  logic                      clr_if;
  logic                      redirect;
  logic                      hlt_exec;
  logic                      inta;
  logic                      nmia;
  logic                      zf;
  logic                      ifl;
  logic                      nmir;
  logic                      block_all;

  core_fetch fetch (
    .clk           (clk),
    .rst           (rst),
    .cpu_dat_i     (cpu_dat_i),
    .block_i       (block_all),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .halt_i        (hlt_exec),
    .instr_o       (instr),
    .pc_o          (pc),
    .state_o       (state)
  );

  core_decode decode (
    .clk           (clk),
    .rst           (rst),
    .instr_i       (instr),
    .state_i       (state),
    .pc_i          (pc),
    .zf_i          (zf),
    .ifl_i         (ifl),
    .intr_i        (intr_i),
    .nmir_i        (nmir),
    .alu_op_o      (alu_op),
    .dst_o         (dst),
    .src_o         (src),
    .reg_we_o      (reg_we),
    .mem_rd_o      (mem_rd),
    .mem_wr_o      (mem_wr),
    .set_if_o      (set_if),
    .clr_if_o      (clr_if),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .hlt_exec_o    (hlt_exec),
    .inta_o        (inta),
    .nmia_o        (nmia)
  );

  core_exec exec (
    .clk       (clk),
    .rst       (rst),
    .state_i   (state),
    .block_i   (block_all),
    .alu_op_i  (alu_op),
    .dst_i     (dst),
    .src_i     (src),
    .imm_i     (instr[7:0]),
    .reg_we_i  (reg_we),
    .mem_rd_i  (mem_rd),
    .mem_wr_i  (mem_wr),
    .set_if_i  (set_if),
    .clr_if_i  (clr_if),
    .cpu_dat_i (cpu_dat_i),
    .mem_adr_o (mem_adr),
    .cpu_dat_o (cpu_dat_o),
    .cpu_we_o  (cpu_we_o),
    .zf_o      (zf),
    .ifl_o     (ifl)
  );

  core_irq_ctrl irq_ctrl (
    .clk         (clk),
    .rst         (rst),
    .nmi_i       (nmi_i),
    .nmia_i      (nmia_o),
    .intr_i      (intr_i),
    .ifl_i       (ifl),
    .hlt_exec_i  (hlt_exec),
    .cpu_block_i (cpu_block_i),
    .nmir_o      (nmir),
    .block_all_o (block_all)
  );

  // data address only during ld/st execute cycles
  assign cpu_adr_o = (mem_rd || mem_wr) ? mem_adr : pc;

  // acknowledges pulse on the completing cycle only
  assign inta_o = inta && !block_all;
  assign nmia_o = nmia && !block_all;
  assign pc_o   = pc;

endmodule

`default_nettype wire

/* design/core_irq_ctrl.sv */
////////////////////////////////////////////////////////////
// interrupt and halt control
// nmi edge request latch, halt latch and combined block
////////////////////////////////////////////////////////////
`default_nettype none
`include "core_config.svh"

module core_irq_ctrl
  import core_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic nmi_i,
  input  logic nmia_i,
  input  logic intr_i,
  input  logic ifl_i,
  input  logic hlt_exec_i,
  input  logic cpu_block_i,
  output logic nmir_o,
  output logic block_all_o
);

  logic nmi_q;
  logic nmia_q;
  logic nmir;
  logic halt_q;
  logic wake;

  assign wake = (intr_i && ifl_i) || nmir;

  // request held until the acknowledge has been seen
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      nmi_q  <= 1'b0;
      nmia_q <= 1'b0;
      nmir   <= 1'b0;
    end
    else
    begin
      nmi_q  <= nmi_i;
      nmia_q <= nmia_i;
      if (nmi_i && !nmi_q)
        nmir <= 1'b1;
      else if (nmia_q)
        nmir <= 1'b0;
    end
  end

  // set when hlt completes, dropped by a wake source
  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      halt_q <= 1'b0;
    else if (hlt_exec_i && !cpu_block_i)
      halt_q <= 1'b1;
    else if (wake)
      halt_q <= 1'b0;
  end

  assign nmir_o      = nmir;
  assign block_all_o = cpu_block_i || halt_q;

endmodule

`default_nettype wire

/* design/core_exec.sv */
////////////////////////////////////////////////////////////
// execute unit
// register file, alu, zero and interrupt-enable flags,
// data bus address and write strobe
////////////////////////////////////////////////////////////
`default_nettype none
`include "core_config.svh"

module core_exec
  import core_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  seq_state_t                state_i,
  input  logic                      block_i,
  input  alu_op_t                   alu_op_i,
  input  logic [$clog2(`NREGS)-1:0] dst_i,
  input  logic [$clog2(`NREGS)-1:0] src_i,
  input  logic [7:0]                imm_i,
  input  logic                      reg_we_i,
  input  logic                      mem_rd_i,
  input  logic                      mem_wr_i,
  input  logic                      set_if_i,
  input  logic                      clr_if_i,
  input  logic [`DATA_W-1:0]        cpu_dat_i,
  output logic [`ADDR_W-1:0]        mem_adr_o,
  output logic [`DATA_W-1:0]        cpu_dat_o,
  output logic                      cpu_we_o,
  output logic                      zf_o,
  output logic                      ifl_o
);

  logic [`DATA_W-1:0] regs [`NREGS];
  logic [`DATA_W-1:0] op_a;
  logic [`DATA_W-1:0] op_b;
  logic [`DATA_W-1:0] alu_res;
  logic [`DATA_W-1:0] wr_data;
  logic               complete;
  logic               zf;
  logic               ifl;

  assign op_a = regs[dst_i];
  // ldi brings its operand from the immediate field
  assign op_b = (alu_op_i == pass_b) ? {{(`DATA_W-8){1'b0}}, imm_i} : regs[src_i];

  always_comb
  begin
    case (alu_op_i)
      pass_b:  alu_res = op_b;
      add:     alu_res = op_a + op_b;
      sub:     alu_res = op_a - op_b;
      default: alu_res = op_a;
    endcase
  end

  assign wr_data = mem_rd_i ? cpu_dat_i : alu_res;

  // execute and halt cycles end on the first unblocked edge
  assign complete = (state_i != fetch_st) && !block_i;

  always_ff @(posedge clk)
  begin
    if (complete && reg_we_i)
      regs[dst_i] <= wr_data;
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      zf  <= 1'b0;
      ifl <= 1'b0;
    end
    else if (complete)
    begin
      // only ldi, add and sub touch the zero flag
      if (alu_op_i != none)
        zf <= (alu_res == '0);
      // acceptance clears, even alongside sti
      if (clr_if_i)
        ifl <= 1'b0;
      else if (set_if_i)
        ifl <= 1'b1;
    end
  end

  // ld and st address through the source register
  assign mem_adr_o = {{(`ADDR_W-`DATA_W){1'b0}}, regs[src_i]};
  assign cpu_dat_o = op_a;
  assign cpu_we_o  = mem_wr_i;
  assign zf_o      = zf;
  assign ifl_o     = ifl;

endmodule

`default_nettype wire

/* design/core_decode.sv */
////////////////////////////////////////////////////////////
// instruction decoder
// execute controls, branch targets, interrupt acceptance
// and the shadow return pc
////////////////////////////////////////////////////////////
`default_nettype none
`include "core_config.svh"

module core_decode
  import core_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [`DATA_W-1:0]         instr_i,
  input  seq_state_t                 state_i,
  input  logic [`ADDR_W-1:0]         pc_i,
  input  logic                       zf_i,
  input  logic                       ifl_i,
  input  logic                       intr_i,
  input  logic                       nmir_i,
  output alu_op_t                    alu_op_o,
  output logic [$clog2(`NREGS)-1:0]  dst_o,
  output logic [$clog2(`NREGS)-1:0]  src_o,
  output logic                       reg_we_o,
  output logic                       mem_rd_o,
  output logic                       mem_wr_o,
  output logic                       set_if_o,
  output logic                       clr_if_o,
  output logic                       redirect_o,
  output logic [`ADDR_W-1:0]         redirect_pc_o,
  output logic                       hlt_exec_o,
  output logic                       inta_o,
  output logic                       nmia_o
);

  opcode_t            op;
  logic               in_exec;
  logic               at_boundary;
  logic               is_jz;
  logic               is_hlt;
  logic               is_stci;
  logic               is_iret;
  logic               jz_take;
  logic               nmi_take;
  logic               irq_take;
  logic [`ADDR_W-1:0] imm_pc;
  logic [`ADDR_W-1:0] return_pc;
  logic [`ADDR_W-1:0] shadow_pc;

  assign op     = opcode_t'(instr_i[15:12]);
  assign dst_o  = instr_i[11:10];
  assign src_o  = instr_i[9:8];
  assign imm_pc = {{(`ADDR_W-8){1'b0}}, instr_i[7:0]};

  assign in_exec = (state_i == exec_st);
  // a halted core also sits at an instruction boundary
  assign at_boundary = in_exec || (state_i == halt_st);

  always_comb
  begin
    alu_op_o = none;
    reg_we_o = 1'b0;
    mem_rd_o = 1'b0;
    mem_wr_o = 1'b0;
    is_jz    = 1'b0;
    is_hlt   = 1'b0;
    is_stci  = 1'b0;
    is_iret  = 1'b0;
    if (in_exec)
    begin
      case (op)
        op_ldi:
        begin
          alu_op_o = pass_b;
          reg_we_o = 1'b1;
        end
        op_add:
        begin
          alu_op_o = add;
          reg_we_o = 1'b1;
        end
        op_sub:
        begin
          alu_op_o = sub;
          reg_we_o = 1'b1;
        end
        op_ld:
        begin
          mem_rd_o = 1'b1;
          reg_we_o = 1'b1;
        end
        op_st:   mem_wr_o = 1'b1;
        op_jz:   is_jz    = 1'b1;
        op_hlt:  is_hlt   = 1'b1;
        op_stci: is_stci  = 1'b1;
        op_iret: is_iret  = 1'b1;
        default: alu_op_o = none;
      endcase
    end
  end

  // nmi wins over the maskable line
  assign nmi_take = at_boundary && nmir_i;
  assign irq_take = at_boundary && intr_i && ifl_i && !nmir_i;
  assign jz_take  = is_jz && zf_i;

  // where the program goes if nothing is accepted
  always_comb
  begin
    if (is_iret)
      return_pc = shadow_pc;
    else if (jz_take)
      return_pc = imm_pc;
    else if (in_exec)
      return_pc = pc_i + `ADDR_W'(1);
    else
      return_pc = pc_i;
  end

  always_comb
  begin
    redirect_o = 1'b1;
    if (nmi_take)
      redirect_pc_o = `NMI_VEC;
    else if (irq_take)
      redirect_pc_o = `INTR_VEC;
    else
    begin
      redirect_pc_o = return_pc;
      redirect_o    = is_iret || jz_take;
    end
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
      shadow_pc <= `RESET_PC;
    else if (nmi_take || irq_take)
      shadow_pc <= return_pc;
  end

  assign set_if_o   = (is_stci && instr_i[0]) || is_iret;
  assign clr_if_o   = (is_stci && !instr_i[0]) || nmi_take || irq_take;
  // an accepted interrupt cancels the halt
  assign hlt_exec_o = is_hlt && !nmi_take && !irq_take;
  assign inta_o     = irq_take;
  assign nmia_o     = nmi_take;

endmodule

`default_nettype wire

/* design/core_fetch.sv */
////////////////////////////////////////////////////////////
// fetch sequencer
// holds the pc, latches the instruction word and steps
// through fetch, execute and halt
////////////////////////////////////////////////////////////
`default_nettype none
`include "core_config.svh"

module core_fetch
  import core_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [`DATA_W-1:0] cpu_dat_i,
  input  logic               block_i,
  input  logic               redirect_i,
  input  logic [`ADDR_W-1:0] redirect_pc_i,
  input  logic               halt_i,
  output logic [`DATA_W-1:0] instr_o,
  output logic [`ADDR_W-1:0] pc_o,
  output seq_state_t         state_o
);

  seq_state_t         state;
  logic [`ADDR_W-1:0] pc;
  logic [`ADDR_W-1:0] next_pc;
  logic [`DATA_W-1:0] instr;

  // pc taken at the end of an execute or halt cycle
  always_comb
  begin
    if (redirect_i)
      next_pc = redirect_pc_i;
    else if (state == exec_st)
      next_pc = pc + `ADDR_W'(1);
    else
      next_pc = pc;
  end

  always_ff @(posedge clk or negedge rst)
  begin
    if (!rst)
    begin
      state <= fetch_st;
      pc    <= `RESET_PC;
    end
    else if (!block_i)
    begin
      case (state)
        fetch_st:
          state <= exec_st;
        exec_st:
        begin
          state <= halt_i ? halt_st : fetch_st;
          pc    <= next_pc;
        end
        default:
        begin
          // block released, resume or enter a handler
          state <= fetch_st;
          pc    <= next_pc;
        end
      endcase
    end
  end

  // instruction word, captured on the completing fetch cycle
  always_ff @(posedge clk)
  begin
    if (state == fetch_st && !block_i)
      instr <= cpu_dat_i;
  end

  assign instr_o = instr;
  assign pc_o    = pc;
  assign state_o = state;

endmodule

`default_nettype wire

/* design/core_pkg.sv */
////////////////////////////////////////////////////////////
// core package
// opcode, sequencer state and alu operation types
////////////////////////////////////////////////////////////
`default_nettype none

package core_pkg;

  // instruction word bits 15:12
  typedef enum logic [3:0] {
    op_nop  = 4'h0,
    op_ldi  = 4'h1,
    op_add  = 4'h2,
    op_sub  = 4'h3,
    op_ld   = 4'h4,
    op_st   = 4'h5,
    op_jz   = 4'h6,
    op_hlt  = 4'h7,
    // imm bit 0 picks sti (1) or cli (0)
    op_stci = 4'h8,
    op_iret = 4'h9
  } opcode_t;

  typedef enum logic [1:0] {
    fetch_st = 2'd0,
    exec_st  = 2'd1,
    halt_st  = 2'd2
  } seq_state_t;

  typedef enum logic [1:0] {
    pass_b = 2'd0,
    add    = 2'd1,
    sub    = 2'd2,
    none   = 2'd3
  } alu_op_t;

endpackage

`default_nettype wire

/* include/core_config.svh */
////////////////////////////////////////////////////////////
// core configuration
// bus widths, reset pc, interrupt vectors, register count
////////////////////////////////////////////////////////////
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// word-addressed bus
`define ADDR_W 20
`define DATA_W 16

// first fetch address out of reset
`define RESET_PC 20'h00000

// fixed handler entry points
`define INTR_VEC 20'h00040
`define NMI_VEC  20'h00080

// general purpose registers
`define NREGS 4

`endif
